// File: verilog/scope_defs.svh
`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// UART bit time in sys_clock cycles.
`define SCOPE_CLKS_PER_BIT 8

// Terminal count of the report period counter.
`define SCOPE_REPORT_PERIOD 400

// Terminal count of the LED pulse counter.
`define SCOPE_LED_PERIOD 50

// Half period of the ADC serial clock.
`define SCOPE_SCLK_HALF 2

// Raw sample width on the parallel bus.
`define SCOPE_ADC_BITS 14

`endif

// File: verilog/adc_pkg.sv
package adc_pkg;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } adc_bytes_t;

    // Capture writes the sample view, the UART reads the byte view.
    typedef union packed {
        logic signed [15:0] sample;
        adc_bytes_t         bytes;
    } adc_word_u;

    typedef struct packed {
        logic      valid;
        adc_word_u ch1;
        adc_word_u ch2;
    } adc_pair_t;

    typedef struct packed {
        logic [15:0] instr;  // R/W bit, length and register address.
        logic [7:0]  data;
    } spi_write_t;

    localparam int ADC_INIT_COUNT = 3;

    localparam spi_write_t ADC_INIT_TABLE [ADC_INIT_COUNT] = '{
        '{instr: 16'h0014, data: 8'h01},  // Two's complement output.
        '{instr: 16'h0016, data: 8'h00},
        '{instr: 16'h00ff, data: 8'h01}   // Transfer.
    };

endpackage

// File: verilog/uart_pkg.sv
package uart_pkg;

    typedef struct packed {
        logic                send;
        adc_pkg::adc_word_u  word;
    } uart_req_t;

    // Frame states.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } uart_state_e;

endpackage

// File: verilog/adc_spi_init.sv
`include "scope_defs.svh"

module adc_spi_init (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_sclk,
    output logic o_cs,
    output logic o_sdio,
    output logic o_init_done
);
    import adc_pkg::*;

    localparam int WORD_W   = $bits(spi_write_t);
    localparam int DIV_MAX  = 2 * `SCOPE_SCLK_HALF - 1;
    localparam int DIV_W    = $clog2(DIV_MAX + 1);
    localparam int BIT_W    = $clog2(WORD_W);
    localparam int IDX_W    = $clog2(ADC_INIT_COUNT);
    localparam int GAP_LAST = 3;

    typedef enum logic [1:0] {
        S_START,
        S_SHIFT,
        S_GAP,
        S_DONE
    } init_state_e;

    init_state_e       state;
    logic [DIV_W-1:0]  div_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [1:0]        gap_cnt;
    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] shreg;

    assign o_sdio = shreg[WORD_W-1];  // MSB first.

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= S_START;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            gap_cnt     <= '0;
            idx         <= '0;
            shreg       <= '0;
            o_sclk      <= 1'b0;
            o_cs        <= 1'b1;
            o_init_done <= 1'b0;
        end else begin
            case (state)
                S_START: begin
                    shreg   <= ADC_INIT_TABLE[0];
                    o_cs    <= 1'b0;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= S_SHIFT;
                end
                S_SHIFT: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == DIV_W'(`SCOPE_SCLK_HALF - 1)) begin
                        o_sclk <= 1'b1;  // ADC samples here.
                    end
                    if (div_cnt == DIV_W'(DIV_MAX)) begin
                        div_cnt <= '0;
                        o_sclk  <= 1'b0;
                        shreg   <= shreg << 1;  // Next bit on the falling edge.
                        if (bit_cnt == BIT_W'(WORD_W - 1)) begin
                            o_cs    <= 1'b1;
                            gap_cnt <= '0;
                            state   <= S_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                S_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == 2'(GAP_LAST)) begin
                        if (idx == IDX_W'(ADC_INIT_COUNT - 1)) begin
                            o_init_done <= 1'b1;
                            state       <= S_DONE;
                        end else begin
                            idx     <= idx + 1'b1;
                            shreg   <= ADC_INIT_TABLE[idx + 1'b1];
                            o_cs    <= 1'b0;
                            div_cnt <= '0;
                            bit_cnt <= '0;
                            state   <= S_SHIFT;
                        end
                    end
                end
                default: begin
                    state <= S_DONE;  // Holds until reset.
                end
            endcase
        end
    end

endmodule

// File: verilog/adc_capture.sv
`include "scope_defs.svh"

module adc_capture (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_init_done,
    input  logic [`SCOPE_ADC_BITS-1:0] i_adc_data,
    output adc_pkg::adc_pair_t         o_pair
);
    import adc_pkg::*;

    logic      phase;  // 0 is ch1, 1 is ch2.
    logic      pair_valid;
    adc_word_u sample_ext;
    adc_word_u ch1_hold;
    adc_word_u pair_ch1;
    adc_word_u pair_ch2;

    assign sample_ext.sample = {{(16 - `SCOPE_ADC_BITS){i_adc_data[`SCOPE_ADC_BITS-1]}},
                                i_adc_data};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase      <= 1'b0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            if (i_init_done) begin
                phase      <= ~phase;
                pair_valid <= phase;  // Pair complete after ch2.
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_init_done && !phase) begin
            ch1_hold <= sample_ext;
        end
        if (i_init_done && phase) begin
            pair_ch1 <= ch1_hold;
            pair_ch2 <= sample_ext;
        end
    end

    assign o_pair.valid = pair_valid;
    assign o_pair.ch1   = pair_ch1;
    assign o_pair.ch2   = pair_ch2;

endmodule

// File: verilog/sample_reporter.sv
`include "scope_defs.svh"

module sample_reporter (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_init_done,
    input  adc_pkg::adc_pair_t  i_pair,
    input  logic                i_ready,
    output uart_pkg::uart_req_t o_req
);
    import adc_pkg::*;

    localparam int CNT_W = $clog2(`SCOPE_REPORT_PERIOD + 1);

    logic [CNT_W-1:0] period_cnt;
    logic             period_end;
    logic             send;
    adc_word_u        ch1_latest;
    adc_word_u        report_word;

    assign period_end = (period_cnt == CNT_W'(`SCOPE_REPORT_PERIOD));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            period_cnt <= '0;
            send       <= 1'b0;
        end else begin
            send <= 1'b0;
            if (period_end) begin
                period_cnt <= '0;
                // Report is lost when busy or not configured.
                send       <= i_ready & i_init_done;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pair.valid) begin
            ch1_latest <= i_pair.ch1;
        end
        if (period_end) begin
            report_word <= ch1_latest;
        end
    end

    assign o_req.send = send;
    assign o_req.word = report_word;

endmodule

// File: verilog/uart_tx.sv
`include "scope_defs.svh"

module uart_tx (
    input  logic                i_clk,
    input  logic                i_rst,
    input  uart_pkg::uart_req_t i_req,
    output logic                o_ready,
    output logic                o_tx
);
    import adc_pkg::*;
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`SCOPE_CLKS_PER_BIT + 1);

    uart_state_e      state;
    logic [CNT_W-1:0] bit_time;
    logic             bit_last;
    logic [2:0]       bit_idx;
    logic             byte_sel;  // 0 is low byte.
    adc_word_u        word;
    logic [7:0]       cur_byte;

    assign bit_last = (bit_time == CNT_W'(`SCOPE_CLKS_PER_BIT - 1));
    assign cur_byte = byte_sel ? word.bytes.hi : word.bytes.lo;
    assign o_ready  = (state == ST_IDLE);

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_req.send) begin
            word <= i_req.word;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            bit_time <= '0;
            bit_idx  <= '0;
            byte_sel <= 1'b0;
            o_tx     <= 1'b1;
        end else begin
            bit_time <= bit_last ? '0 : bit_time + 1'b1;
            case (state)
                ST_IDLE: begin
                    bit_time <= '0;
                    o_tx     <= 1'b1;
                    if (i_req.send) begin
                        byte_sel <= 1'b0;
                        o_tx     <= 1'b0;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_last) begin
                        bit_idx <= '0;
                        o_tx    <= cur_byte[0];  // LSB first.
                        state   <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (bit_last) begin
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            o_tx    <= cur_byte[bit_idx + 3'd1];
                        end
                    end
                end
                default: begin
                    if (bit_last) begin
                        if (!byte_sel) begin
                            byte_sel <= 1'b1;  // High byte, no gap.
                            o_tx     <= 1'b0;
                            state    <= ST_START;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/status_led.sv
`include "scope_defs.svh"

module status_led (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_init_done,
    output logic o_led_g,
    output logic o_led_r
);

    localparam int CNT_W = $clog2(`SCOPE_LED_PERIOD + 1);

    logic [CNT_W-1:0] pulse_cnt;
    logic             pulse;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pulse_cnt <= '0;
            pulse     <= 1'b0;
        end else if (pulse_cnt == CNT_W'(`SCOPE_LED_PERIOD)) begin
            pulse_cnt <= '0;
            pulse     <= 1'b1;
        end else begin
            pulse_cnt <= pulse_cnt + 1'b1;
            pulse     <= 1'b0;
        end
    end

    // Red while configuring.
    assign o_led_r = pulse & ~i_init_done;
    assign o_led_g = pulse & i_init_done;

endmodule

// File: verilog/scope_top.sv
`include "scope_defs.svh"

module scope_top (
    input  logic                       sys_clock,
    input  logic                       i_rst,
    input  logic [`SCOPE_ADC_BITS-1:0] i_adc_data,
    output logic                       o_adc_sclk,
    output logic                       o_adc_cs,
    output logic                       o_adc_sdio,
    output logic                       o_tx,
    output logic                       o_led_g,
    output logic                       o_led_r
);
    import adc_pkg::*;
    import uart_pkg::*;

    logic      init_done;
    adc_pair_t pair;
    uart_req_t req;
    logic      uart_ready;

    adc_spi_init u_adc_spi_init (
        .i_clk       (sys_clock),
        .i_rst       (i_rst),
        .o_sclk      (o_adc_sclk),
        .o_cs        (o_adc_cs),
        .o_sdio      (o_adc_sdio),
        .o_init_done (init_done)
    );

    adc_capture u_adc_capture (
        .i_clk       (sys_clock),
        .i_rst       (i_rst),
        .i_init_done (init_done),
        .i_adc_data  (i_adc_data),
        .o_pair      (pair)
    );

    sample_reporter u_sample_reporter (
        .i_clk       (sys_clock),
        .i_rst       (i_rst),
        .i_init_done (init_done),
        .i_pair      (pair),
        .i_ready     (uart_ready),
        .o_req       (req)
    );

    uart_tx u_uart_tx (
        .i_clk   (sys_clock),
        .i_rst   (i_rst),
        .i_req   (req),
        .o_ready (uart_ready),
        .o_tx    (o_tx)
    );

    status_led u_status_led (
        .i_clk       (sys_clock),
        .i_rst       (i_rst),
        .i_init_done (init_done),
        .o_led_g     (o_led_g),
        .o_led_r     (o_led_r)
    );

endmodule

// File: bench/tb_scope_top.sv
`include "scope_defs.svh"

module tb_scope_top;
    timeunit 1ns;
    timeprecision 1ps;
    import adc_pkg::*;

    localparam int PERIOD      = `SCOPE_REPORT_PERIOD + 1;
    localparam int LED_GAP     = `SCOPE_LED_PERIOD + 1;
    localparam int BIT_CYCLES  = `SCOPE_CLKS_PER_BIT;
    localparam int INIT_CYCLES = ADC_INIT_COUNT * (48 * `SCOPE_SCLK_HALF + 5) + 4;
    localparam int RUN_CYCLES  = 2 * (16 + INIT_CYCLES) + 200 + 6 * PERIOD;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES * 12 / 10;

    localparam int T_CFG     = 0;
    localparam int T_LED     = 1;
    localparam int T_FRAME   = 2;
    localparam int T_VALUE   = 3;
    localparam int T_SPACING = 4;
    localparam int T_RESET   = 5;

    logic        sys_clock = 1'b0;
    logic        i_rst;
    logic [13:0] i_adc_data;
    logic        o_adc_sclk;
    logic        o_adc_cs;
    logic        o_adc_sdio;
    logic        o_tx;
    logic        o_led_g;
    logic        o_led_r;

    string test_name [6] = '{"config_stream", "led_status", "uart_framing",
                             "sample_value", "report_spacing", "reset_recovery"};
    int          checks [6];
    int          fails [6];
    logic [31:0] rng;
    logic [13:0] v;  // ch1 value for the current report period.
    int          rises;
    int          since;  // Cycles since the last config write ended.
    int          writes;
    int          reports;
    int          spi_bits;
    logic [23:0] spi_word;
    logic        prev_cs;
    logic        prev_sclk;
    time         last_red;
    time         last_green;
    time         last_start;
    bit          have_start;

    scope_top u_scope_top (.*);

    always #5 sys_clock = ~sys_clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [15:0] sign_extend(input logic [13:0] d);
        return {{2{d[13]}}, d};
    endfunction

    task automatic note_failure(input int t, input string msg);
        fails[t]++;
        $display("%s: %s at %0t", test_name[t], msg, $time);
    endtask

    task automatic check_equal(input int t, input logic [31:0] exp, input logic [31:0] act);
        checks[t]++;
        assert (act === exp) else begin
            fails[t]++;
            $display("FAILED %s expected %0h actual %0h", test_name[t], exp, act);
        end
    endtask

    task automatic check_true(input int t, input logic cond, input string msg);
        checks[t]++;
        assert (cond === 1'b1) else note_failure(t, msg);
    endtask

    sdio_on_low_sclk: assert property (@(posedge sys_clock) disable iff (i_rst)
        (!o_adc_cs && $changed(o_adc_sdio)) |-> !o_adc_sclk)
        else note_failure(T_CFG, "sdio changed while sclk was high");

    led_one_cycle: assert property (@(posedge sys_clock) disable iff (i_rst)
        (o_led_r || o_led_g) |=> !(o_led_r || o_led_g))
        else note_failure(T_LED, "LED pulse longer than one cycle");

    led_exclusive: assert property (@(posedge sys_clock) !(o_led_r && o_led_g))
        else note_failure(T_LED, "both LEDs lit together");

    // Serial decoder, LED monitor and ADC bus driver.
    always @(posedge sys_clock) begin
        if (i_rst) begin
            rises      = 0;
            since      = 0;
            spi_bits   = 0;
            last_red   = 0;
            last_green = 0;
            i_adc_data <= v;
        end else begin
            if (!o_adc_cs && o_adc_sclk && !prev_sclk) begin
                spi_word = {spi_word[22:0], o_adc_sdio};
                spi_bits++;
            end
            if (o_adc_cs && !prev_cs) begin
                check_equal(T_CFG, 24, spi_bits);
                check_equal(T_CFG, {8'h00, ADC_INIT_TABLE[writes % ADC_INIT_COUNT]},
                            {8'h00, spi_word});
                writes++;
                rises++;
                spi_bits = 0;
                if (rises == ADC_INIT_COUNT)
                    since = 1;
            end else if (since > 0) begin
                since++;
            end
            if (rises < ADC_INIT_COUNT)
                check_true(T_LED, !o_led_g, "green LED pulsed during configuration");
            if (since >= 5)
                check_true(T_LED, !o_led_r, "red LED pulsed after configuration");
            if (o_led_r) begin
                if (last_red != 0)
                    check_equal(T_LED, LED_GAP, int'(($time - last_red) / 10));
                last_red = $time;
            end
            if (o_led_g) begin
                if (last_green != 0)
                    check_equal(T_LED, LED_GAP, int'(($time - last_green) / 10));
                last_green = $time;
            end
            // Capture phase 0 samples the value driven when since is 4.
            i_adc_data <= (since >= 4 && since % 2 == 1) ? ~v : v;
        end
        prev_cs   = o_adc_cs;
        prev_sclk = o_adc_sclk;
    end

    // UART decoder, sampling mid-bit.
    initial begin : uart_decoder
        logic [7:0]  byte_val;
        logic [15:0] word;
        logic [15:0] expected;
        forever begin
            @(posedge sys_clock);
            if (!i_rst && o_tx == 1'b0) begin
                check_true(T_FRAME, since >= 5, "frame started before configuration ended");
                if (have_start)
                    check_equal(T_SPACING, PERIOD, int'(($time - last_start) / 10));
                last_start = $time;
                have_start = 1'b1;
                expected   = sign_extend(v);
                fork
                    begin
                        repeat (50) @(posedge sys_clock);
                        @(negedge sys_clock);
                        rng = xorshift(rng);
                        v   = rng[13:0];
                    end
                join_none
                for (int b = 0; b < 2; b++) begin
                    if (b == 1) begin
                        repeat (4) @(posedge sys_clock);
                        check_true(T_FRAME, o_tx == 1'b0, "gap between the two frames");
                    end
                    repeat (4) @(posedge sys_clock);
                    check_true(T_FRAME, o_tx == 1'b0, "start bit not low");
                    for (int i = 0; i < 8; i++) begin
                        repeat (BIT_CYCLES) @(posedge sys_clock);
                        byte_val[i] = o_tx;
                    end
                    repeat (BIT_CYCLES) @(posedge sys_clock);
                    check_true(T_FRAME, o_tx == 1'b1, "stop bit not high");
                    word = (b == 1) ? {byte_val, word[7:0]} : {8'h00, byte_val};
                end
                check_equal(T_VALUE, {16'h0000, expected}, {16'h0000, word});
                repeat (4) @(posedge sys_clock);
                reports++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge sys_clock);
        $display("Timeout after %0d cycles, the expected reports never arrived",
                 WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        int total_checks;
        int total_fails;
        i_rst      = 1'b1;
        i_adc_data = '0;
        rng        = xorshift(32'hb134);
        v          = rng[13:0];
        repeat (16) @(posedge sys_clock);
        i_rst <= 1'b0;
        wait (reports == 3);
        repeat (200) @(posedge sys_clock);
        i_rst <= 1'b1;
        repeat (2) @(posedge sys_clock);
        for (int i = 2; i < 16; i++) begin
            check_true(T_RESET, o_tx == 1'b1, "tx not idle under reset");
            check_true(T_RESET, o_adc_cs == 1'b1, "chip select low under reset");
            check_true(T_RESET, !o_led_r && !o_led_g, "LED lit under reset");
            @(posedge sys_clock);
        end
        have_start = 1'b0;
        i_rst <= 1'b0;
        wait (reports == 6);
        check_equal(T_RESET, 2 * ADC_INIT_COUNT, writes);
        check_true(T_LED, last_red != 0, "red LED never pulsed during configuration");
        check_true(T_LED, last_green != 0, "green LED never pulsed after configuration");
        total_checks = 0;
        total_fails  = 0;
        for (int t = 0; t < 6; t++) begin
            $display("test %s: %0d checks, %0d failures", test_name[t], checks[t], fails[t]);
            total_checks += checks[t];
            total_fails  += fails[t];
        end
        $display("Totals: %0d checks, %0d failures", total_checks, total_fails);
        if (total_fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/adc_pkg.sv
verilog/uart_pkg.sv
verilog/adc_spi_init.sv
verilog/adc_capture.sv
verilog/sample_reporter.sv
verilog/uart_tx.sv
verilog/status_led.sv
verilog/scope_top.sv
bench/tb_scope_top.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_scope_top -f tb.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "No result line in sim.log"
    exit 1
fi
exit 0
